//--- led_panel_consts.svh
// Panel geometry, colour depth and scan read path latencies
`ifndef LED_PANEL_CONSTS_SVH
`define LED_PANEL_CONSTS_SVH

// Addressable rows in one segment
`define SCAN_ROWS 4

// Columns shifted out per line
`define PANEL_COLUMNS 8

// Vertically stacked segments scanned side by side
`define SEGMENTS 2

// Bits per colour channel
`define PIXEL_BITWIDTH 4

// Read address to frame buffer output
`define FRAME_READ_LATENCY 1

// Raw scan word to corrected scan word
`define GAMMA_LATENCY 1

// Wait between first column address and the first colour compare
`define LOAD_DELAY (`FRAME_READ_LATENCY + `GAMMA_LATENCY)

`endif

//--- led_panel_pkg.sv
// Package with pixel, scan word, address, row, column, rgb bit and PWM cycle types
`include "led_panel_consts.svh"

package led_panel_pkg;

	// Segment index never narrower than one bit
	localparam int SEGMENT_BITS = (`SEGMENTS > 1) ? $clog2(`SEGMENTS) : 1;

	typedef struct packed {
		logic [`PIXEL_BITWIDTH-1:0] r;
		logic [`PIXEL_BITWIDTH-1:0] g;
		logic [`PIXEL_BITWIDTH-1:0] b;
	} pixel_t;

	// One pixel per segment, segment 0 in the low bits
	typedef pixel_t [`SEGMENTS-1:0] scan_word_t;

	typedef logic [$clog2(`SCAN_ROWS)-1:0] row_t;
	typedef logic [$clog2(`PANEL_COLUMNS)-1:0] column_t;
	typedef logic [SEGMENT_BITS-1:0] segment_t;

	typedef struct packed {
		segment_t segment;
		row_t row;
		column_t column;
	} pixel_addr_t;

	// Bit 3*s is red, 3*s+1 green, 3*s+2 blue of segment s
	typedef logic [3*`SEGMENTS-1:0] rgb_bits_t;

	// Top bit set only on the final dummy cycle
	typedef logic [`PIXEL_BITWIDTH:0] pwm_cycle_t;

endpackage

//--- frame_buffer.sv
// Banked pixel memory with four-phase host write port and registered scan read port
`timescale 1ns/10ps
`include "led_panel_consts.svh"

module frame_buffer (
	input logic clk,
	input logic rst,
	// Host write side
	input logic wr_req,
	input led_panel_pkg::pixel_addr_t wr_addr,
	input led_panel_pkg::pixel_t wr_data,
	output logic wr_ack,
	// Scan read side
	input led_panel_pkg::row_t rd_row,
	input led_panel_pkg::column_t rd_column,
	output led_panel_pkg::scan_word_t rd_data
);
	import led_panel_pkg::*;

	// Words per bank, one bank per segment
	localparam int DEPTH = `SCAN_ROWS * `PANEL_COLUMNS;
	localparam int INDEX_BITS = $bits(row_t) + $bits(column_t);

	logic wr_start;
	logic [INDEX_BITS-1:0] wr_index;
	logic [INDEX_BITS-1:0] rd_index;

	// Rising edge of the handshake, req seen high while ack still low
	assign wr_start = wr_req && !wr_ack;

	// Row major word index inside a bank
	assign wr_index = {wr_addr.row, wr_addr.column};
	assign rd_index = {rd_row, rd_column};

	// Ack follows req by one cycle in both directions
	// This gives rise after req high and fall after req low
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ack <= 1'b0;
		end else begin
			wr_ack <= wr_req;
		end
	end

	for (genvar s = 0; s < `SEGMENTS; s++) begin : g_bank
		pixel_t bank [DEPTH];

		// Only the addressed segment takes the host word
		always_ff @(posedge clk) begin
			if (wr_start && (wr_addr.segment == segment_t'(s))) begin
				bank[wr_index] <= wr_data;
			end
		end

		// All banks read at the same row and column
		// One cycle of read latency
		always_ff @(posedge clk) begin
			rd_data[s] <= bank[rd_index];
		end
	end

endmodule

//--- gamma_corrector.sv
// Registered gamma mapping of every channel of a scan word through an elaborated table
`timescale 1ns/10ps
`include "led_panel_consts.svh"

module gamma_corrector (
	input logic clk,
	input logic rst,
	input led_panel_pkg::scan_word_t raw,
	output led_panel_pkg::scan_word_t corrected
);
	import led_panel_pkg::*;

	localparam int LEVELS = 2 ** `PIXEL_BITWIDTH;

	typedef logic [`PIXEL_BITWIDTH-1:0] level_t;
	typedef level_t lut_t [LEVELS];

	// Ceiling of v squared over full range
	// 0 maps to 0 and full scale maps to full scale
	function automatic lut_t build_lut();
		lut_t lut;
		for (int v = 0; v < LEVELS; v++) begin
			lut[v] = level_t'((v * v + LEVELS - 1) / LEVELS);
		end
		return lut;
	endfunction

	localparam lut_t GAMMA_LUT = build_lut();

	// Same table for red, green and blue
	function automatic pixel_t correct_pixel(input pixel_t p);
		pixel_t q;
		q.r = GAMMA_LUT[p.r];
		q.g = GAMMA_LUT[p.g];
		q.b = GAMMA_LUT[p.b];
		return q;
	endfunction

	// One cycle through the stage for all segments
	always_ff @(posedge clk) begin
		if (rst) begin
			corrected <= '0;
		end else begin
			for (int s = 0; s < `SEGMENTS; s++) begin
				corrected[s] <= correct_pixel(raw[s]);
			end
		end
	end

endmodule

//--- column_shifter.sv
// Column address counter, colour bit compare against the PWM cycle and oclk shift sequence
`timescale 1ns/10ps
`include "led_panel_consts.svh"

module column_shifter (
	input logic clk,
	input logic rst,
	input logic row_req,
	output logic row_ack,
	input led_panel_pkg::pwm_cycle_t cycle,
	input led_panel_pkg::scan_word_t pixel,
	output led_panel_pkg::column_t column,
	output led_panel_pkg::rgb_bits_t rgb,
	output logic oclk
);
	import led_panel_pkg::*;

	localparam int DELAY_BITS = $clog2(`LOAD_DELAY + 1);
	localparam column_t LAST_COLUMN = column_t'(`PANEL_COLUMNS - 1);

	typedef enum logic [2:0] {
		S_WAIT,
		S_ADDR,
		S_LOAD_DELAY,
		S_RGB_BITS,
		S_PUSH,
		S_PUSH_HOLD,
		S_HOLD
	} state_t;

	state_t state;
	logic [DELAY_BITS-1:0] delay_count;
	// Columns already pushed in this load
	column_t push_count;
	rgb_bits_t rgb_next;

	// Lit when nonzero and not below the cycle level
	function automatic logic bit_on(
		input logic [`PIXEL_BITWIDTH-1:0] value,
		input logic [`PIXEL_BITWIDTH-1:0] level
	);
		return (value != '0) && (value >= level);
	endfunction

	// Dummy cycle compares as cycle 0 through its low bits
	always_comb begin
		for (int s = 0; s < `SEGMENTS; s++) begin
			rgb_next[3*s+0] = bit_on(pixel[s].r, cycle[`PIXEL_BITWIDTH-1:0]);
			rgb_next[3*s+1] = bit_on(pixel[s].g, cycle[`PIXEL_BITWIDTH-1:0]);
			rgb_next[3*s+2] = bit_on(pixel[s].b, cycle[`PIXEL_BITWIDTH-1:0]);
		end
	end

	// Column address runs two clocks per column and leads the compare
	// Address c is set 2c clocks after load start, compared LOAD_DELAY+1 later
	// oclk rises the clock after each compare and falls one clock on
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_WAIT;
			delay_count <= '0;
			push_count <= '0;
			column <= '0;
			rgb <= '0;
			oclk <= 1'b0;
			row_ack <= 1'b0;
		end else begin
			oclk <= (state == S_PUSH);
			case (state)
				S_WAIT: begin
					if (row_req) begin
						state <= S_ADDR;
					end
				end
				S_ADDR: begin
					column <= '0;
					delay_count <= '0;
					state <= S_LOAD_DELAY;
				end
				// Column 0 travels through memory and gamma stage
				S_LOAD_DELAY: begin
					if (delay_count == DELAY_BITS'(`LOAD_DELAY - 1)) begin
						column <= column + 1'b1;
						state <= S_RGB_BITS;
					end else begin
						delay_count <= delay_count + 1'b1;
					end
				end
				S_RGB_BITS: begin
					rgb <= rgb_next;
					push_count <= '0;
					state <= S_PUSH;
				end
				// Next address goes out while this column is clocked
				S_PUSH: begin
					if (column != LAST_COLUMN) begin
						column <= column + 1'b1;
					end
					state <= S_PUSH_HOLD;
				end
				S_PUSH_HOLD: begin
					if (push_count == LAST_COLUMN) begin
						row_ack <= 1'b1;
						state <= S_HOLD;
					end else begin
						rgb <= rgb_next;
						push_count <= push_count + 1'b1;
						state <= S_PUSH;
					end
				end
				// Ack held until the controller drops its request
				S_HOLD: begin
					if (!row_req) begin
						row_ack <= 1'b0;
						state <= S_WAIT;
					end
				end
				default: begin
					state <= S_WAIT;
				end
			endcase
		end
	end

endmodule

//--- pwm_cycle_controller.sv
// PWM cycle counter with row load requests and latch and output enable sequencing
`timescale 1ns/10ps
`include "led_panel_consts.svh"

module pwm_cycle_controller (
	input logic clk,
	input logic rst,
	input logic cycle_req,
	output logic cycle_ack,
	output logic row_req,
	input logic row_ack,
	output led_panel_pkg::pwm_cycle_t cycle,
	output logic lat,
	output logic oe
);
	import led_panel_pkg::*;

	// Load after the last real cycle, only times the final display
	localparam pwm_cycle_t DUMMY_CYCLE = pwm_cycle_t'(2 ** `PIXEL_BITWIDTH);

	typedef enum logic [2:0] {
		S_WAIT,
		S_LOAD,
		S_LOAD_WAIT,
		S_LATCH,
		S_LATCH_HOLD,
		S_HOLD
	} state_t;

	state_t state;

	// Per row: load 0, then per k drop oe, latch, raise oe, load k
	// Latch k shows the compare against cycle k-1
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_WAIT;
			cycle <= '0;
			cycle_ack <= 1'b0;
			row_req <= 1'b0;
			lat <= 1'b0;
			oe <= 1'b0;
		end else begin
			case (state)
				S_WAIT: begin
					if (cycle_req) begin
						state <= S_LOAD;
					end
				end
				// One clock after lat fell, display the latched data
				// Request waits for the previous ack to clear
				S_LOAD: begin
					oe <= (cycle != '0);
					if (!row_ack) begin
						row_req <= 1'b1;
						state <= S_LOAD_WAIT;
					end
				end
				// oe drops ahead of the latch or to end the dummy display
				S_LOAD_WAIT: begin
					if (row_ack) begin
						row_req <= 1'b0;
						oe <= 1'b0;
						if (cycle == DUMMY_CYCLE) begin
							cycle <= '0;
							cycle_ack <= 1'b1;
							state <= S_HOLD;
						end else begin
							cycle <= cycle + 1'b1;
							state <= S_LATCH;
						end
					end
				end
				S_LATCH: begin
					lat <= 1'b1;
					state <= S_LATCH_HOLD;
				end
				S_LATCH_HOLD: begin
					lat <= 1'b0;
					state <= S_LOAD;
				end
				S_HOLD: begin
					if (!cycle_req) begin
						cycle_ack <= 1'b0;
						state <= S_WAIT;
					end
				end
				default: begin
					state <= S_WAIT;
				end
			endcase
		end
	end

endmodule

//--- scan_sequencer.sv
// Scan row stepping with one PWM display request per row and the end of frame pulse
`timescale 1ns/10ps
`include "led_panel_consts.svh"

module scan_sequencer (
	input logic clk,
	input logic rst,
	output logic cycle_req,
	input logic cycle_ack,
	output led_panel_pkg::row_t row,
	output logic frame_complete
);
	import led_panel_pkg::*;

	localparam row_t LAST_ROW = row_t'(`SCAN_ROWS - 1);

	typedef enum logic [1:0] {
		S_REQUEST,
		S_ACK_WAIT,
		S_FRAME_DONE
	} state_t;

	state_t state;

	// Row only moves while oe is low after the dummy load
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_REQUEST;
			row <= '0;
			cycle_req <= 1'b0;
			frame_complete <= 1'b0;
		end else begin
			case (state)
				// New request only once the last ack has cleared
				S_REQUEST: begin
					if (!cycle_ack) begin
						cycle_req <= 1'b1;
						state <= S_ACK_WAIT;
					end
				end
				S_ACK_WAIT: begin
					if (cycle_ack) begin
						cycle_req <= 1'b0;
						if (row == LAST_ROW) begin
							row <= '0;
							frame_complete <= 1'b1;
							state <= S_FRAME_DONE;
						end else begin
							row <= row + 1'b1;
							state <= S_REQUEST;
						end
					end
				end
				// Single cycle frame pulse, row 0 already addressed
				S_FRAME_DONE: begin
					frame_complete <= 1'b0;
					state <= S_REQUEST;
				end
				default: begin
					state <= S_REQUEST;
				end
			endcase
		end
	end

endmodule

//--- led_panel_top.sv
// Top level joining frame buffer, gamma stage and the three panel control machines
`timescale 1ns/10ps

module led_panel_top (
	input logic clk,
	input logic rst,
	// Host pixel writes
	input logic wr_req,
	input led_panel_pkg::pixel_addr_t wr_addr,
	input led_panel_pkg::pixel_t wr_data,
	output logic wr_ack,
	// HUB75 panel side
	output led_panel_pkg::row_t row,
	output led_panel_pkg::column_t column,
	output led_panel_pkg::rgb_bits_t rgb,
	output logic oe,
	output logic lat,
	output logic oclk,
	output logic frame_complete
);
	import led_panel_pkg::*;

	// Scan read path
	scan_word_t raw_pixels;
	scan_word_t corrected_pixels;

	// Machine to machine handshakes
	pwm_cycle_t cycle;
	logic cycle_req;
	logic cycle_ack;
	logic row_req;
	logic row_ack;

	// Row from the sequencer and column from the shifter address memory
	frame_buffer frame_buffer_i (
		.clk(clk),
		.rst(rst),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_ack(wr_ack),
		.rd_row(row),
		.rd_column(column),
		.rd_data(raw_pixels)
	);

	gamma_corrector gamma_corrector_i (
		.clk(clk),
		.rst(rst),
		.raw(raw_pixels),
		.corrected(corrected_pixels)
	);

	column_shifter column_shifter_i (
		.clk(clk),
		.rst(rst),
		.row_req(row_req),
		.row_ack(row_ack),
		.cycle(cycle),
		.pixel(corrected_pixels),
		.column(column),
		.rgb(rgb),
		.oclk(oclk)
	);

	pwm_cycle_controller pwm_cycle_controller_i (
		.clk(clk),
		.rst(rst),
		.cycle_req(cycle_req),
		.cycle_ack(cycle_ack),
		.row_req(row_req),
		.row_ack(row_ack),
		.cycle(cycle),
		.lat(lat),
		.oe(oe)
	);

	scan_sequencer scan_sequencer_i (
		.clk(clk),
		.rst(rst),
		.cycle_req(cycle_req),
		.cycle_ack(cycle_ack),
		.row(row),
		.frame_complete(frame_complete)
	);

endmodule

//--- tb_led_panel.sv
// Testbench for the LED panel driver with host writes, panel output model and checks
`timescale 1ns/10ps
`include "led_panel_consts.svh"

module tb_led_panel;
	import led_panel_pkg::*;

	localparam int MAX_CYCLES = 10000;
	localparam int LATCHES_PER_ROW = 2 ** `PIXEL_BITWIDTH;
	localparam row_t LAST_ROW = row_t'(`SCAN_ROWS - 1);

	logic clk;
	logic rst;
	logic wr_req;
	pixel_addr_t wr_addr;
	pixel_t wr_data;
	logic wr_ack;
	row_t row;
	column_t column;
	rgb_bits_t rgb;
	logic oe;
	logic lat;
	logic oclk;
	logic frame_complete;

	integer seed = 32'h9d90_5594;
	int error_count = 0;
	int cycle_count = 0;
	int frames_checked = 0;
	logic writes_done = 1'b0;
	logic frame_armed = 1'b0;

	// Host side copy of every written pixel
	pixel_t model [`SEGMENTS][`SCAN_ROWS][`PANEL_COLUMNS];
	// Latched on count per pixel and channel over one frame
	int lit_count [`SEGMENTS][`SCAN_ROWS][`PANEL_COLUMNS][3];
	// Panel shift register, far end at index 0
	rgb_bits_t shift_reg [`PANEL_COLUMNS];

	// Previous sample of the panel side for edge detection
	logic prev_rst = 1'b1;
	logic prev_ack = 1'b0;
	logic prev_oclk = 1'b0;
	logic prev_lat = 1'b0;
	logic prev_fc = 1'b0;
	row_t prev_row = '0;
	int oclk_count = 0;
	int lat_in_row = 0;

	led_panel_top led_panel_top_i (
		.clk(clk),
		.rst(rst),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_ack(wr_ack),
		.row(row),
		.column(column),
		.rgb(rgb),
		.oe(oe),
		.lat(lat),
		.oclk(oclk),
		.frame_complete(frame_complete)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("** Error (%0t): %s", $time, msg);
	endtask

	// Ceiling of v squared over the level count, plus the cycle 0 latch when lit
	function automatic int expected_count(input int value);
		int levels;
		int squared;
		int corrected;
		levels = 2 ** `PIXEL_BITWIDTH;
		squared = value * value;
		corrected = squared / levels;
		if (corrected * levels != squared) begin
			corrected++;
		end
		return (corrected == 0) ? 0 : corrected + 1;
	endfunction

	function automatic int channel_value(input pixel_t p, input int ch);
		return (ch == 0) ? int'(p.r) : (ch == 1) ? int'(p.g) : int'(p.b);
	endfunction

	// Four phase write, each phase allowed two cycles
	task automatic write_pixel(input int seg, input int r, input int c, input pixel_t value);
		pixel_addr_t addr;
		int waited;
		addr.segment = segment_t'(seg);
		addr.row = row_t'(r);
		addr.column = column_t'(c);
		@(posedge clk);
		wr_addr <= addr;
		wr_data <= value;
		wr_req <= 1'b1;
		waited = 1;
		@(negedge clk);
		while (!wr_ack) begin
			waited++;
			@(negedge clk);
		end
		assert (waited <= 2) else report_error($sformatf("wr_ack rose after %0d cycles", waited));
		@(posedge clk);
		wr_req <= 1'b0;
		waited = 1;
		@(negedge clk);
		while (wr_ack) begin
			waited++;
			@(negedge clk);
		end
		assert (waited <= 2) else report_error($sformatf("wr_ack fell after %0d cycles", waited));
	endtask

	task automatic check_frame();
		int want;
		foreach (lit_count[s, r, c, ch]) begin
			want = expected_count(channel_value(model[s][r][c], ch));
			assert (lit_count[s][r][c][ch] == want) else report_error($sformatf(
				"segment %0d row %0d column %0d channel %0d lit %0d times, expected %0d",
				s, r, c, ch, lit_count[s][r][c][ch], want));
		end
	endtask

	// Outputs sampled on the falling edge, half a clock after they change
	always @(negedge clk) begin
		if (rst || prev_rst) begin
			assert (!oe && !lat && !oclk && !frame_complete && !wr_ack)
				else report_error("control outputs not low in reset");
			assert (row == '0 && column == '0 && rgb == '0)
				else report_error("row, column or rgb not zero in reset");
		end else begin
			// Handshake edges only in the matching req phase
			if (wr_ack && !prev_ack) begin
				assert (wr_req) else report_error("wr_ack rose while wr_req low");
			end
			if (!wr_ack && prev_ack) begin
				assert (!wr_req) else report_error("wr_ack fell while wr_req high");
			end
			assert (!(lat && oe)) else report_error("oe high during lat");
			if (oclk && !prev_oclk) begin
				for (int c = 0; c < `PANEL_COLUMNS - 1; c++) begin
					shift_reg[c] = shift_reg[c+1];
				end
				shift_reg[`PANEL_COLUMNS-1] = rgb;
				oclk_count++;
			end
			// Latch copies the shift register onto the current row
			if (lat && !prev_lat) begin
				assert (oclk_count == `PANEL_COLUMNS)
					else report_error($sformatf("%0d oclk rises before lat", oclk_count));
				oclk_count = 0;
				lat_in_row++;
				for (int s = 0; s < `SEGMENTS; s++) begin
					for (int c = 0; c < `PANEL_COLUMNS; c++) begin
						for (int ch = 0; ch < 3; ch++) begin
							lit_count[s][row][c][ch] += int'(shift_reg[c][3*s+ch]);
						end
					end
				end
			end
			if (row != prev_row) begin
				assert (lat_in_row == LATCHES_PER_ROW)
					else report_error($sformatf("row %0d got %0d latches", prev_row, lat_in_row));
				assert (row == ((prev_row == LAST_ROW) ? row_t'(0) : row_t'(prev_row + 1)))
					else report_error($sformatf("row stepped from %0d to %0d", prev_row, row));
				assert (frame_complete == (prev_row == LAST_ROW))
					else report_error("frame_complete out of step with row wrap");
				lat_in_row = 0;
				oclk_count = 0;
			end else begin
				assert (!frame_complete) else report_error("frame_complete without row wrap");
			end
			assert (!(frame_complete && prev_fc)) else report_error("frame_complete longer than 1 cycle");
			// First full frame after the writes arms the check
			if (frame_complete) begin
				if (frame_armed) begin
					check_frame();
					frames_checked++;
				end else if (writes_done) begin
					frame_armed = 1'b1;
				end
				foreach (lit_count[s, r, c, ch]) begin
					lit_count[s][r][c][ch] = 0;
				end
			end
		end
		prev_rst = rst;
		prev_ack = wr_ack;
		prev_oclk = oclk;
		prev_lat = lat;
		prev_fc = frame_complete;
		prev_row = row;
	end

	// Three frames plus writes and margin
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: %0d frames checked after %0d cycles", frames_checked, cycle_count);
			$display("Errors: %0d", error_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		pixel_t value;
		rst <= 1'b1;
		wr_req <= 1'b0;
		wr_addr <= '0;
		wr_data <= '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int s = 0; s < `SEGMENTS; s++) begin
			for (int r = 0; r < `SCAN_ROWS; r++) begin
				for (int c = 0; c < `PANEL_COLUMNS; c++) begin
					value = pixel_t'($random(seed));
					model[s][r][c] = value;
					write_pixel(s, r, c, value);
				end
			end
		end
		@(posedge clk);
		writes_done = 1'b1;
		wait (frames_checked == 2);
		$display("Errors: %0d, frames checked: %0d", error_count, frames_checked);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+.
led_panel_pkg.sv
frame_buffer.sv
gamma_corrector.sv
column_shifter.sv
pwm_cycle_controller.sv
scan_sequencer.sv
led_panel_top.sv
tb_led_panel.sv
